//--- compile.f
design/rename_pkg.sv
design/free_reg_finder.sv
design/free_list.sv
design/rename_map.sv
design/rename_csr.sv
design/rename_top.sv
testbench/rename_chk.sv
testbench/rename_tb.sv

//--- testbench/rename_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rename_tb;

    typedef struct packed {
        rename_pkg::rename_req_t  req_0;
        rename_pkg::rename_req_t  req_1;
        logic                     pause;
        logic                     recover;
        rename_pkg::commit_info_t commit_0;
        rename_pkg::commit_info_t commit_1;
        logic                     exp_alloc;
        rename_pkg::rename_resp_t exp_0;
        rename_pkg::rename_resp_t exp_1;
    } row_t;

    logic                     clk;
    logic                     rst;
    logic [7:0]               paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;
    rename_pkg::rename_req_t  req_0;
    rename_pkg::rename_req_t  req_1;
    logic                     pause;
    logic                     recover;
    rename_pkg::commit_info_t commit_0;
    rename_pkg::commit_info_t commit_1;
    rename_pkg::rename_resp_t resp_0;
    rename_pkg::rename_resp_t resp_1;
    logic                     allocatable;

    row_t rows[$];
    int   next_row;
    int   cycle_count;
    int   cycle_limit;
    int   error_count;

    rename_top rename_top_inst (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .req_0       (req_0),
        .req_1       (req_1),
        .pause       (pause),
        .recover     (recover),
        .commit_0    (commit_0),
        .commit_1    (commit_1),
        .resp_0      (resp_0),
        .resp_1      (resp_1),
        .allocatable (allocatable)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // bound assertions update their count at the rising edge
    always @(negedge clk) begin
        assert (rename_top_inst.rename_chk_inst.fail_count == 0) else begin
            $display("Error at %0t ns: a bound assertion on the rename block failed", $time);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first error");
        end
    end

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        error_count++;
        $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else fail_value(name, got, exp);
    endtask

    // dst is undefined when the pair cannot be allocated
    task automatic check_resp(input string slot, input rename_pkg::rename_resp_t got,
                              input rename_pkg::rename_resp_t exp, input logic chk_dst);
        if (chk_dst) begin
            check_value({slot, ".prf_dst"}, 32'(got.prf_dst), 32'(exp.prf_dst));
        end
        check_value({slot, ".prf_stale"}, 32'(got.prf_stale), 32'(exp.prf_stale));
        check_value({slot, ".prf_src0"}, 32'(got.prf_src0), 32'(exp.prf_src0));
        check_value({slot, ".prf_src1"}, 32'(got.prf_src1), 32'(exp.prf_src1));
    endtask

    function automatic rename_pkg::rename_req_t req_of(input int dst, input int s0, input int s1);
        rename_pkg::rename_req_t r;
        r.valid     = 1'b1;
        r.dst_en    = 1'b1;
        r.arch_dst  = rename_pkg::arch_idx_t'(dst);
        r.arch_src0 = rename_pkg::arch_idx_t'(s0);
        r.arch_src1 = rename_pkg::arch_idx_t'(s1);
        return r;
    endfunction

    function automatic rename_pkg::commit_info_t commit_of(input int dst, input int prf,
                                                           input int stale);
        rename_pkg::commit_info_t c;
        c.valid         = 1'b1;
        c.wr_reg_commit = 1'b1;
        c.arch_dst      = rename_pkg::arch_idx_t'(dst);
        c.committed_prf = rename_pkg::prf_idx_t'(prf);
        c.stale_prf     = rename_pkg::prf_idx_t'(stale);
        return c;
    endfunction

    function automatic rename_pkg::rename_resp_t resp_of(input int dst, input int stale,
                                                         input int s0, input int s1);
        rename_pkg::rename_resp_t r;
        r.prf_dst   = rename_pkg::prf_idx_t'(dst);
        r.prf_stale = rename_pkg::prf_idx_t'(stale);
        r.prf_src0  = rename_pkg::prf_idx_t'(s0);
        r.prf_src1  = rename_pkg::prf_idx_t'(s1);
        return r;
    endfunction

    task automatic add_row(input rename_pkg::rename_req_t r0, input rename_pkg::rename_req_t r1,
                           input logic p, input logic rc,
                           input rename_pkg::commit_info_t c0, input rename_pkg::commit_info_t c1,
                           input logic ea,
                           input rename_pkg::rename_resp_t e0, input rename_pkg::rename_resp_t e1);
        row_t row;
        row.req_0     = r0;
        row.req_1     = r1;
        row.pause     = p;
        row.recover   = rc;
        row.commit_0  = c0;
        row.commit_1  = c1;
        row.exp_alloc = ea;
        row.exp_0     = e0;
        row.exp_1     = e1;
        rows.push_back(row);
    endtask

    task automatic build_table();
        rename_pkg::rename_req_t fill_0;
        rename_pkg::rename_req_t fill_1;
        int d0;
        int d1;
        int prev0;
        int prev1;
        fill_0 = req_of(20, 5, 2);
        fill_1 = req_of(21, 20, 0);
        // fresh destinations straight after reset
        add_row(req_of(1, 2, 3), req_of(2, 4, 5), 0, 0, '0, '0, 1,
                resp_of(1, 0, 0, 0), resp_of(2, 0, 0, 0));
        add_row(req_of(3, 1, 2), req_of(4, 3, 1), 0, 0, '0, '0, 1,
                resp_of(3, 0, 1, 2), resp_of(4, 0, 3, 1));
        // both slots write r1
        add_row(req_of(1, 1, 4), req_of(1, 1, 3), 0, 0, '0, '0, 1,
                resp_of(5, 1, 1, 4), resp_of(6, 5, 5, 3));
        add_row('0, req_of(5, 1, 2), 0, 0, '0, '0, 1, '0, resp_of(7, 0, 6, 2));
        add_row('0, '0, 0, 0, commit_of(1, 1, 0), commit_of(2, 2, 0), 1, '0, '0);
        add_row('0, '0, 0, 0, commit_of(3, 3, 0), commit_of(4, 4, 0), 1, '0, '0);
        // frees 1 and 5
        add_row('0, '0, 0, 0, commit_of(1, 5, 1), commit_of(1, 6, 5), 1, '0, '0);
        add_row(req_of(6, 1, 5), req_of(7, 6, 0), 0, 0, '0, '0, 1,
                resp_of(1, 0, 6, 7), resp_of(5, 0, 1, 0));
        add_row(req_of(8, 6, 7), req_of(2, 8, 5), 0, 0, '0, '0, 1,
                resp_of(8, 0, 1, 5), resp_of(9, 2, 8, 7));
        // recover beats the request in the same cycle
        add_row(req_of(10, 1, 2), '0, 0, 1, '0, '0, 1, resp_of(10, 0, 6, 9), '0);
        add_row(req_of(5, 1, 2), req_of(2, 7, 8), 0, 0, '0, '0, 1,
                resp_of(1, 0, 6, 2), resp_of(5, 2, 0, 0));
        // paused, while a commit frees register 2
        add_row(fill_0, fill_1, 1, 0, commit_of(5, 1, 0), commit_of(2, 5, 2), 1,
                resp_of(7, 0, 1, 5), resp_of(8, 0, 7, 0));
        // held by the ctrl register
        add_row(fill_0, fill_1, 0, 0, '0, '0, 1, resp_of(2, 0, 1, 5), resp_of(7, 0, 2, 0));
        // drain the free list down to two registers
        prev0 = 0;
        prev1 = 0;
        for (int k = 0; k < 28; k++) begin
            d0 = (k == 0) ? 2 : 2 * k + 6;
            d1 = (k == 0) ? 7 : 2 * k + 7;
            add_row(fill_0, fill_1, 0, 0, '0, '0, 1,
                    resp_of(d0, prev0, 1, 5), resp_of(d1, prev1, d0, 0));
            prev0 = d0;
            prev1 = d1;
        end
        add_row(fill_0, '0, 0, 0, '0, '0, 1, resp_of(62, 60, 1, 5), '0);
        // one free register, two requests
        add_row(fill_0, fill_1, 0, 0, commit_of(20, 2, 0), commit_of(21, 7, 0), 0,
                resp_of(63, 62, 1, 5), resp_of(0, 61, 63, 0));
        add_row(fill_0, fill_1, 0, 0, commit_of(20, 8, 2), commit_of(21, 9, 7), 0,
                resp_of(63, 62, 1, 5), resp_of(0, 61, 63, 0));
        add_row(fill_0, fill_1, 0, 0, '0, '0, 1, resp_of(2, 62, 1, 5), resp_of(7, 61, 2, 0));
    endtask

    task automatic drive_idle();
        req_0    = '0;
        req_1    = '0;
        pause    = 1'b0;
        recover  = 1'b0;
        commit_0 = '0;
        commit_1 = '0;
    endtask

    task automatic apply_row(input row_t r);
        @(negedge clk);
        req_0    = r.req_0;
        req_1    = r.req_1;
        pause    = r.pause;
        recover  = r.recover;
        commit_0 = r.commit_0;
        commit_1 = r.commit_1;
        #1;
        check_value("allocatable", 32'(allocatable), 32'(r.exp_alloc));
        if (r.req_0.valid) begin
            check_resp("resp_0", resp_0, r.exp_0, r.exp_alloc);
        end
        if (r.req_1.valid) begin
            check_resp("resp_1", resp_1, r.exp_1, r.exp_alloc);
        end
    endtask

    task automatic run_rows(input int count);
        repeat (count) begin
            apply_row(rows[next_row]);
            next_row++;
        end
        @(negedge clk);
        drive_idle();
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic err);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        check_value("pready", 32'(pready), 32'(1'b1));
        check_value("pslverr", 32'(pslverr), 32'(err));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp, input logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        check_value("pready", 32'(pready), 32'(1'b1));
        check_value("pslverr", 32'(pslverr), 32'(err));
        if (!err) begin
            check_value("prdata", prdata, exp);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        drive_idle();
        next_row    = 0;
        cycle_count = 0;
        error_count = 0;
        build_table();
        cycle_limit = 4 * rows.size() + 200;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        apb_read(rename_pkg::reg_free, 63, 0);
        apb_read(rename_pkg::reg_committed_free, 63, 0);
        apb_read(rename_pkg::reg_ctrl, 0, 0);
        apb_read(rename_pkg::reg_alloc_count, 0, 0);
        apb_read(rename_pkg::reg_recover_count, 0, 0);
        run_rows(4);
        run_rows(3);
        apb_read(rename_pkg::reg_free, 58, 0);
        apb_read(rename_pkg::reg_committed_free, 59, 0);
        run_rows(1);
        apb_read(rename_pkg::reg_alloc_count, 9, 0);
        apb_read(rename_pkg::reg_free, 56, 0);

        // speculative work thrown away by recover
        run_rows(2);
        apb_read(rename_pkg::reg_free, 59, 0);
        apb_read(rename_pkg::reg_committed_free, 59, 0);
        apb_read(rename_pkg::reg_alloc_count, 11, 0);
        apb_read(rename_pkg::reg_recover_count, 1, 0);

        run_rows(2);
        apb_read(rename_pkg::reg_free, 58, 0);
        apb_read(rename_pkg::reg_committed_free, 58, 0);
        apb_read(rename_pkg::reg_alloc_count, 13, 0);
        apb_write(rename_pkg::reg_ctrl, 1, 0);
        run_rows(1);
        apb_read(rename_pkg::reg_ctrl, 1, 0);
        apb_read(rename_pkg::reg_alloc_count, 13, 0);
        apb_write(rename_pkg::reg_ctrl, 0, 0);

        run_rows(32);
        apb_read(rename_pkg::reg_free, 1, 0);
        apb_read(rename_pkg::reg_committed_free, 56, 0);
        apb_read(rename_pkg::reg_alloc_count, 72, 0);

        // unmapped offset and a read-only count
        apb_read(8'h14, 0, 1);
        apb_write(8'h14, 0, 1);
        apb_write(rename_pkg::reg_free, 0, 0);
        apb_read(rename_pkg::reg_free, 1, 0);

        if (error_count == 0 && rename_top_inst.rename_chk_inst.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/rename_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rename_chk (
    input wire                       clk,
    input wire                       rst,
    input wire                       psel,
    input wire                       penable,
    input wire                       pready,
    input wire                       alloc_0,
    input wire                       alloc_1,
    input wire rename_pkg::prf_idx_t new_prf_0,
    input wire rename_pkg::prf_idx_t new_prf_1
);

    // number of assertion failures so far
    int fail_count = 0;

    // physical 0 stays with r0
    grant_0_nonzero: assert property (@(posedge clk) disable iff (rst)
        alloc_0 |-> new_prf_0 != '0)
        else begin
            fail_count++;
            $error("slot 0 was granted physical register 0");
        end

    grant_1_nonzero: assert property (@(posedge clk) disable iff (rst)
        alloc_1 |-> new_prf_1 != '0)
        else begin
            fail_count++;
            $error("slot 1 was granted physical register 0");
        end

    pair_distinct: assert property (@(posedge clk) disable iff (rst)
        (alloc_0 && alloc_1) |-> new_prf_0 != new_prf_1)
        else begin
            fail_count++;
            $error("both slots were granted the same physical register");
        end

    // no wait states on the bus
    access_ready: assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |-> pready)
        else begin
            fail_count++;
            $error("pready low during an APB access phase");
        end

endmodule

bind rename_top rename_chk rename_chk_inst (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .alloc_0   (alloc_0),
    .alloc_1   (alloc_1),
    .new_prf_0 (new_prf_0),
    .new_prf_1 (new_prf_1)
);

`default_nettype wire

//--- design/rename_top.sv
`timescale 1ns/10ps
`default_nettype none

module rename_top (
    input  wire                           clk,
    input  wire                           rst,
    input  wire [7:0]                     paddr,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire [31:0]                    pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  wire rename_pkg::rename_req_t  req_0,
    input  wire rename_pkg::rename_req_t  req_1,
    input  wire                           pause,
    input  wire                           recover,
    input  wire rename_pkg::commit_info_t commit_0,
    input  wire rename_pkg::commit_info_t commit_1,
    output rename_pkg::rename_resp_t      resp_0,
    output rename_pkg::rename_resp_t      resp_1,
    output logic                          allocatable
);

    logic                  stall;
    logic                  want_0;
    logic                  want_1;
    logic                  alloc_0;
    logic                  alloc_1;
    rename_pkg::prf_idx_t  new_prf_0;
    rename_pkg::prf_idx_t  new_prf_1;
    rename_pkg::free_cnt_t free_count;
    rename_pkg::free_cnt_t committed_free_count;

    rename_csr rename_csr_inst (
        .clk                  (clk),
        .rst                  (rst),
        .paddr                (paddr),
        .psel                 (psel),
        .penable              (penable),
        .pwrite               (pwrite),
        .pwdata               (pwdata),
        .prdata               (prdata),
        .pready               (pready),
        .pslverr              (pslverr),
        .pause                (pause),
        .recover              (recover),
        .alloc_0              (alloc_0),
        .alloc_1              (alloc_1),
        .free_count           (free_count),
        .committed_free_count (committed_free_count),
        .stall                (stall)
    );

    free_list free_list_inst (
        .clk                  (clk),
        .rst                  (rst),
        .recover              (recover),
        .stall                (stall),
        .want_0               (want_0),
        .want_1               (want_1),
        .commit_0             (commit_0),
        .commit_1             (commit_1),
        .new_prf_0            (new_prf_0),
        .new_prf_1            (new_prf_1),
        .alloc_0              (alloc_0),
        .alloc_1              (alloc_1),
        .allocatable          (allocatable),
        .free_count           (free_count),
        .committed_free_count (committed_free_count)
    );

    rename_map rename_map_inst (
        .clk         (clk),
        .rst         (rst),
        .recover     (recover),
        .stall       (stall),
        .allocatable (allocatable),
        .req_0       (req_0),
        .req_1       (req_1),
        .new_prf_0   (new_prf_0),
        .new_prf_1   (new_prf_1),
        .commit_0    (commit_0),
        .commit_1    (commit_1),
        .resp_0      (resp_0),
        .resp_1      (resp_1),
        .want_0      (want_0),
        .want_1      (want_1)
    );

endmodule

`default_nettype wire

//--- design/rename_csr.sv
`timescale 1ns/10ps
`default_nettype none

module rename_csr (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [7:0]                  paddr,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire [31:0]                 pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  wire                        pause,
    input  wire                        recover,
    input  wire                        alloc_0,
    input  wire                        alloc_1,
    input  wire rename_pkg::free_cnt_t free_count,
    input  wire rename_pkg::free_cnt_t committed_free_count,
    output logic                       stall
);

    logic        hold;
    logic [31:0] alloc_count;
    logic [31:0] recover_count;
    logic        access;
    logic        addr_hit;

    // no wait states
    assign pready = 1'b1;
    assign access = psel && penable;

    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            rename_pkg::reg_ctrl:           prdata = {31'b0, hold};
            rename_pkg::reg_free:           prdata = {25'b0, free_count};
            rename_pkg::reg_committed_free: prdata = {25'b0, committed_free_count};
            rename_pkg::reg_alloc_count:    prdata = alloc_count;
            rename_pkg::reg_recover_count:  prdata = recover_count;
            default:                        addr_hit = 1'b0;
        endcase
    end

    assign pslverr = access && !addr_hit;

    // only the hold bit is writable
    always_ff @(posedge clk) begin
        if (rst) begin
            hold <= 1'b0;
        end else if (access && pwrite && paddr == rename_pkg::reg_ctrl) begin
            hold <= pwdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_count   <= '0;
            recover_count <= '0;
        end else begin
            alloc_count   <= alloc_count + 32'(alloc_0) + 32'(alloc_1);
            recover_count <= recover_count + 32'(recover);
        end
    end

    assign stall = pause || hold;

endmodule

`default_nettype wire

//--- design/rename_map.sv
`timescale 1ns/10ps
`default_nettype none

module rename_map (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           recover,
    input  wire                           stall,
    input  wire                           allocatable,
    input  wire rename_pkg::rename_req_t  req_0,
    input  wire rename_pkg::rename_req_t  req_1,
    input  wire rename_pkg::prf_idx_t     new_prf_0,
    input  wire rename_pkg::prf_idx_t     new_prf_1,
    input  wire rename_pkg::commit_info_t commit_0,
    input  wire rename_pkg::commit_info_t commit_1,
    output rename_pkg::rename_resp_t      resp_0,
    output rename_pkg::rename_resp_t      resp_1,
    output logic                          want_0,
    output logic                          want_1
);

    rename_pkg::prf_idx_t spec_map [rename_pkg::arch_count];
    rename_pkg::prf_idx_t comm_map [rename_pkg::arch_count];
    rename_pkg::prf_idx_t comm_next [rename_pkg::arch_count];

    logic do_alloc_0;
    logic do_alloc_1;

    assign want_0 = req_0.valid && req_0.dst_en;
    assign want_1 = req_1.valid && req_1.dst_en;

    // same grant condition as the free list
    assign do_alloc_0 = want_0 && allocatable && !stall && !recover;
    assign do_alloc_1 = want_1 && allocatable && !stall && !recover;

    // slot 0 reads the map as it stands
    assign resp_0.prf_dst   = new_prf_0;
    assign resp_0.prf_stale = spec_map[req_0.arch_dst];
    assign resp_0.prf_src0  = spec_map[req_0.arch_src0];
    assign resp_0.prf_src1  = spec_map[req_0.arch_src1];

    // slot 1 sees slot 0's rename first
    assign resp_1.prf_dst   = new_prf_1;
    assign resp_1.prf_stale = (want_0 && req_0.arch_dst == req_1.arch_dst)
                            ? new_prf_0 : spec_map[req_1.arch_dst];
    assign resp_1.prf_src0  = (want_0 && req_0.arch_dst == req_1.arch_src0)
                            ? new_prf_0 : spec_map[req_1.arch_src0];
    assign resp_1.prf_src1  = (want_0 && req_0.arch_dst == req_1.arch_src1)
                            ? new_prf_0 : spec_map[req_1.arch_src1];

    // commit_1 is younger and wins a shared arch_dst
    always_comb begin
        comm_next = comm_map;
        if (commit_0.valid && commit_0.wr_reg_commit) begin
            comm_next[commit_0.arch_dst] = commit_0.committed_prf;
        end
        if (commit_1.valid && commit_1.wr_reg_commit) begin
            comm_next[commit_1.arch_dst] = commit_1.committed_prf;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            comm_map <= '{default: '0};
        end else begin
            comm_map <= comm_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_map <= '{default: '0};
        end else if (recover) begin
            spec_map <= comm_next;
        end else begin
            if (do_alloc_0) begin
                spec_map[req_0.arch_dst] <= new_prf_0;
            end
            // slot 1 written last, so it wins a shared destination
            if (do_alloc_1) begin
                spec_map[req_1.arch_dst] <= new_prf_1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/free_list.sv
`timescale 1ns/10ps
`default_nettype none

module free_list (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           recover,
    input  wire                           stall,
    input  wire                           want_0,
    input  wire                           want_1,
    input  wire rename_pkg::commit_info_t commit_0,
    input  wire rename_pkg::commit_info_t commit_1,
    output rename_pkg::prf_idx_t          new_prf_0,
    output rename_pkg::prf_idx_t          new_prf_1,
    output logic                          alloc_0,
    output logic                          alloc_1,
    output logic                          allocatable,
    output rename_pkg::free_cnt_t         free_count,
    output rename_pkg::free_cnt_t         committed_free_count
);

    localparam int n = rename_pkg::prf_count;

    // 1 = busy, 0 = free
    logic [n-1:0] spec_busy;
    logic [n-1:0] comm_busy;
    logic [n-1:0] busy_after_0;
    logic [n-1:0] spec_next;
    logic [n-1:0] comm_next;

    logic found_0;
    logic found_1;
    logic rel_0;
    logic rel_1;
    logic new_0;
    logic new_1;

    rename_pkg::prf_idx_t  idx_0;
    rename_pkg::prf_idx_t  idx_1;
    rename_pkg::free_cnt_t need;
    rename_pkg::free_cnt_t spec_cnt_next;
    rename_pkg::free_cnt_t comm_cnt_next;

    function automatic logic [n-1:0] bit_of(input rename_pkg::prf_idx_t idx);
        logic [n-1:0] v;
        v      = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    function automatic logic commit_writes(input rename_pkg::commit_info_t c);
        return c.valid && c.wr_reg_commit;
    endfunction

    free_reg_finder finder_0 (
        .busy  (spec_busy),
        .found (found_0),
        .idx   (idx_0)
    );

    // slot 1 searches with slot 0's pick already taken
    assign busy_after_0 = want_0 ? (spec_busy | bit_of(idx_0)) : spec_busy;

    free_reg_finder finder_1 (
        .busy  (busy_after_0),
        .found (found_1),
        .idx   (idx_1)
    );

    assign new_prf_0 = idx_0;
    assign new_prf_1 = idx_1;

    assign need = rename_pkg::free_cnt_t'(want_0) + rename_pkg::free_cnt_t'(want_1);

    assign allocatable = (need <= free_count) && (!want_0 || found_0) && (!want_1 || found_1);

    assign alloc_0 = want_0 && allocatable && !stall && !recover;
    assign alloc_1 = want_1 && allocatable && !stall && !recover;

    // commits that hand a register back vs. first writes of an arch reg
    assign rel_0 = commit_writes(commit_0) && (commit_0.stale_prf != '0);
    assign rel_1 = commit_writes(commit_1) && (commit_1.stale_prf != '0);
    assign new_0 = commit_writes(commit_0) && (commit_0.stale_prf == '0);
    assign new_1 = commit_writes(commit_1) && (commit_1.stale_prf == '0);

    // committed copy: stale goes free, committed reg becomes busy
    always_comb begin
        comm_next = comm_busy;
        if (commit_writes(commit_0)) begin
            comm_next = (comm_next & ~bit_of(commit_0.stale_prf)) | bit_of(commit_0.committed_prf);
        end
        if (commit_writes(commit_1)) begin
            comm_next = (comm_next & ~bit_of(commit_1.stale_prf)) | bit_of(commit_1.committed_prf);
        end
        comm_next[0] = 1'b1;

        comm_cnt_next = committed_free_count
                      - rename_pkg::free_cnt_t'(new_0)
                      - rename_pkg::free_cnt_t'(new_1);
    end

    // speculative copy: grants first, then commit freeing
    always_comb begin
        spec_next = spec_busy;
        if (alloc_0) begin
            spec_next = spec_next | bit_of(idx_0);
        end
        if (alloc_1) begin
            spec_next = spec_next | bit_of(idx_1);
        end
        if (commit_writes(commit_0)) begin
            spec_next = spec_next & ~bit_of(commit_0.stale_prf);
        end
        if (commit_writes(commit_1)) begin
            spec_next = spec_next & ~bit_of(commit_1.stale_prf);
        end
        spec_next[0] = 1'b1;

        spec_cnt_next = free_count
                      - rename_pkg::free_cnt_t'(alloc_0)
                      - rename_pkg::free_cnt_t'(alloc_1)
                      + rename_pkg::free_cnt_t'(rel_0)
                      + rename_pkg::free_cnt_t'(rel_1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            comm_busy            <= bit_of('0);
            committed_free_count <= rename_pkg::free_cnt_t'(n - 1);
        end else begin
            comm_busy            <= comm_next;
            committed_free_count <= comm_cnt_next;
        end
    end

    // recover takes the committed state including this cycle's commits
    always_ff @(posedge clk) begin
        if (rst) begin
            spec_busy  <= bit_of('0);
            free_count <= rename_pkg::free_cnt_t'(n - 1);
        end else if (recover) begin
            spec_busy  <= comm_next;
            free_count <= comm_cnt_next;
        end else begin
            spec_busy  <= spec_next;
            free_count <= spec_cnt_next;
        end
    end

endmodule

`default_nettype wire

//--- design/free_reg_finder.sv
`timescale 1ns/10ps
`default_nettype none

module free_reg_finder (
    input  wire [rename_pkg::prf_count-1:0] busy,
    output logic                            found,
    output rename_pkg::prf_idx_t            idx
);

    // scan from the top so the lowest clear bit is the last one written
    always_comb begin
        found = 1'b0;
        idx   = '0;
        for (int i = rename_pkg::prf_count - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                found = 1'b1;
                idx   = rename_pkg::prf_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/rename_pkg.sv
`default_nettype none

package rename_pkg;

    // physical and architectural register file sizes
    localparam int prf_count  = 64;
    localparam int arch_count = 32;

    typedef logic [5:0] prf_idx_t;
    typedef logic [4:0] arch_idx_t;

    // counts up to prf_count, so one bit wider than an index
    typedef logic [6:0] free_cnt_t;

    // one instruction entering rename
    typedef struct packed {
        logic      valid;
        logic      dst_en;
        arch_idx_t arch_dst;
        arch_idx_t arch_src0;
        arch_idx_t arch_src1;
    } rename_req_t;

    // physical registers handed back for one slot
    typedef struct packed {
        prf_idx_t prf_dst;
        prf_idx_t prf_stale;
        prf_idx_t prf_src0;
        prf_idx_t prf_src1;
    } rename_resp_t;

    // one retiring instruction
    typedef struct packed {
        logic      valid;
        logic      wr_reg_commit;
        arch_idx_t arch_dst;
        prf_idx_t  committed_prf;
        prf_idx_t  stale_prf;
    } commit_info_t;

    // apb register map
    localparam logic [7:0] reg_ctrl            = 8'h00;
    localparam logic [7:0] reg_free            = 8'h04;
    localparam logic [7:0] reg_committed_free  = 8'h08;
    localparam logic [7:0] reg_alloc_count     = 8'h0C;
    localparam logic [7:0] reg_recover_count   = 8'h10;

endpackage

`default_nettype wire
